// ==== common/dcache_array_if.sv ====
`timescale 1ns/1ps

interface dcache_array_if import dcache_pkg::*; ();

    // read port, data valid one cycle after rd_en
    logic               rd_en;
    logic [INDEX_W-1:0] rd_index;
    tag_entry_t         rd_tag;
    logic [XLEN-1:0]    rd_data;

    // store hit write
    logic               wr_en;
    logic [INDEX_W-1:0] wr_index;
    logic [7:0]         wr_mask;
    logic [XLEN-1:0]    wr_data;
    tag_entry_t         wr_tag;

    // refill, full line
    logic               fill_en;
    logic [INDEX_W-1:0] fill_index;
    logic [XLEN-1:0]    fill_data;
    tag_entry_t         fill_tag;

    logic               init_done;

    modport pipe (
        output rd_en, rd_index, wr_en, wr_index, wr_mask, wr_data, wr_tag,
        input  rd_tag, rd_data, init_done
    );

    modport refill (
        output fill_en, fill_index, fill_data, fill_tag
    );

    modport array (
        input  rd_en, rd_index, wr_en, wr_index, wr_mask, wr_data, wr_tag,
        input  fill_en, fill_index, fill_data, fill_tag,
        output rd_tag, rd_data, init_done
    );

endinterface

// ==== common/dcache_pkg.sv ====
package dcache_pkg;

    //////////////////////////////////////////////////
    // geometry
    localparam int ADDR_W    = 32;
    localparam int XLEN      = 64;
    localparam int OFFSET_W  = 3;
    localparam int INDEX_W   = 8;
    localparam int TAG_W     = 21;
    localparam int NUM_LINES = 256;
    localparam int TAG_LSB   = 11;
    localparam int ROB_W     = 2;   // response tag

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    // bit 2 set means zero extension on loads
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_D  = 3'b011,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101,
        SIZE_WU = 3'b110
    } mem_size_e;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_WRITEBACK,
        MISS_REFILL
    } miss_state_e;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        mem_op_e           op;
        mem_size_e         size;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   st_data;
        logic [ROB_W-1:0]  rob;
        tag_entry_t        victim;       // entry read in s1
        logic [XLEN-1:0]   victim_data;
    } miss_req_t;

    //////////////////////////////////////////////////
    // byte lane helpers
    function automatic logic [XLEN-1:0] load_align(input logic [XLEN-1:0] line,
                                                   input logic [OFFSET_W-1:0] offset,
                                                   input mem_size_e size);
        logic [XLEN-1:0] shifted;
        shifted = line >> {offset, 3'b000};
        case (size)
            SIZE_B:  return {{56{shifted[7]}}, shifted[7:0]};
            SIZE_H:  return {{48{shifted[15]}}, shifted[15:0]};
            SIZE_W:  return {{32{shifted[31]}}, shifted[31:0]};
            SIZE_BU: return {56'b0, shifted[7:0]};
            SIZE_HU: return {48'b0, shifted[15:0]};
            SIZE_WU: return {32'b0, shifted[31:0]};
            default: return shifted;    // doubleword
        endcase
    endfunction

    function automatic logic [7:0] byte_mask(input mem_size_e size,
                                             input logic [OFFSET_W-1:0] offset);
        logic [7:0] base;
        case (size[1:0])
            2'b00:   base = 8'h01;
            2'b01:   base = 8'h03;
            2'b10:   base = 8'h0f;
            default: base = 8'hff;
        endcase
        return base << offset;
    endfunction

    function automatic logic [XLEN-1:0] store_merge(input logic [XLEN-1:0] line,
                                                    input logic [XLEN-1:0] st_data,
                                                    input mem_size_e size,
                                                    input logic [OFFSET_W-1:0] offset);
        logic [7:0]      mask;
        logic [XLEN-1:0] placed;
        logic [XLEN-1:0] merged;
        mask   = byte_mask(size, offset);
        placed = st_data << {offset, 3'b000};
        for (int b = 0; b < XLEN / 8; b++) begin
            merged[8*b +: 8] = mask[b] ? placed[8*b +: 8] : line[8*b +: 8];
        end
        return merged;
    endfunction

endpackage

// ==== compile.f ====
common/dcache_pkg.sv
common/dcache_array_if.sv
dcache/dcache_arrays.sv
dcache/dcache_pipeline.sv
dcache/dcache_miss_unit.sv
verilog/dcache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_wb_mem.sv
testbench/tb_dcache_properties.sv
testbench/tb_dcache.sv

// ==== dcache/dcache_arrays.sv ====
`timescale 1ns/1ps

module dcache_arrays import dcache_pkg::*; (
    input logic           clk,
    input logic           rst_n_i,
    dcache_array_if.array arr
);

    tag_entry_t         tag_mem  [NUM_LINES];
    logic [XLEN-1:0]    data_mem [NUM_LINES];

    logic [INDEX_W-1:0] clr_cnt;
    logic               clr_busy;

    //////////////////////////////////////////////////
    // clear sweep, held at index 0 during reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            clr_cnt  <= '0;
            clr_busy <= 1'b1;
        end else if (clr_busy) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (clr_cnt == INDEX_W'(NUM_LINES - 1)) begin
                clr_busy <= 1'b0;   // last index written
            end
        end
    end

    assign arr.init_done = ~clr_busy;

    //////////////////////////////////////////////////
    // writes: clear, then fill, then store hit
    always_ff @(posedge clk) begin
        if (clr_busy) begin
            tag_mem[clr_cnt]  <= '0;
            data_mem[clr_cnt] <= '0;
        end else if (arr.fill_en) begin
            tag_mem[arr.fill_index]  <= arr.fill_tag;
            data_mem[arr.fill_index] <= arr.fill_data;
        end else if (arr.wr_en) begin
            tag_mem[arr.wr_index] <= arr.wr_tag;
            for (int b = 0; b < XLEN / 8; b++) begin
                if (arr.wr_mask[b]) begin
                    data_mem[arr.wr_index][8*b +: 8] <= arr.wr_data[8*b +: 8];
                end
            end
        end
    end

    // registered read
    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            arr.rd_tag  <= tag_mem[arr.rd_index];
            arr.rd_data <= data_mem[arr.rd_index];
        end
    end

endmodule

// ==== dcache/dcache_miss_unit.sv ====
`timescale 1ns/1ps

module dcache_miss_unit import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    dcache_array_if.refill    arr,

    input  logic              miss_valid_i,
    input  miss_req_t         miss_req_i,
    output logic              mshr_busy_o,

    output logic              fill_resp_valid_o,
    output logic [XLEN-1:0]   fill_ld_data_o,
    output logic [ROB_W-1:0]  fill_rob_o,

    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output logic [XLEN-1:0]   wb_dat_o,
    input  logic              wb_ack_i,
    input  logic [XLEN-1:0]   wb_dat_i
);

    miss_state_e       state;
    miss_req_t         mshr;
    logic              cyc_q;
    logic              bus_done;
    logic              refill_done;
    logic              fill_en_q;
    logic              fill_resp_q;
    logic [XLEN-1:0]   fill_data_q;
    tag_entry_t        fill_tag_q;
    logic [XLEN-1:0]   fill_ld_q;
    logic [ROB_W-1:0]  fill_rob_q;
    logic [OFFSET_W-1:0] mshr_off;

    assign mshr_off    = mshr.addr[OFFSET_W-1:0];
    assign bus_done    = cyc_q && wb_ack_i;
    assign refill_done = bus_done && state == MISS_REFILL;

    //////////////////////////////////////////////////
    // writeback / refill FSM
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state       <= MISS_IDLE;
            cyc_q       <= 1'b0;
            fill_en_q   <= 1'b0;
            fill_resp_q <= 1'b0;
        end else begin
            // cyc drops for a cycle after every ack
            cyc_q       <= (state != MISS_IDLE) && !bus_done;
            fill_en_q   <= refill_done;
            fill_resp_q <= refill_done && mshr.op == OP_LOAD;
            case (state)
                MISS_IDLE: begin
                    if (miss_valid_i) begin
                        state <= (miss_req_i.victim.valid && miss_req_i.victim.dirty) ?
                                 MISS_WRITEBACK : MISS_REFILL;
                    end
                end
                MISS_WRITEBACK: if (bus_done) state <= MISS_REFILL;
                MISS_REFILL:    if (bus_done) state <= MISS_IDLE;
                default:        state <= MISS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_valid_i && state == MISS_IDLE) begin
            mshr <= miss_req_i;
        end
        if (refill_done) begin
            fill_data_q <= (mshr.op == OP_STORE) ?
                           store_merge(wb_dat_i, mshr.st_data, mshr.size, mshr_off) : wb_dat_i;
            fill_tag_q  <= '{valid: 1'b1, dirty: mshr.op == OP_STORE,
                             tag: mshr.addr[ADDR_W-1:TAG_LSB]};
            fill_ld_q   <= load_align(wb_dat_i, mshr_off, mshr.size);
            fill_rob_q  <= mshr.rob;
        end
    end

    // busy through the fill cycle
    assign mshr_busy_o = (state != MISS_IDLE) || fill_en_q;

    //////////////////////////////////////////////////
    // wishbone
    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_we_o  = state == MISS_WRITEBACK;
    assign wb_adr_o = (state == MISS_WRITEBACK) ?
                      {mshr.victim.tag, mshr.addr[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}} :
                      {mshr.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign wb_dat_o = mshr.victim_data;

    assign arr.fill_en    = fill_en_q;
    assign arr.fill_index = mshr.addr[OFFSET_W +: INDEX_W];
    assign arr.fill_data  = fill_data_q;
    assign arr.fill_tag   = fill_tag_q;

    assign fill_resp_valid_o = fill_resp_q;
    assign fill_ld_data_o    = fill_ld_q;
    assign fill_rob_o        = fill_rob_q;

endmodule

// ==== dcache/dcache_pipeline.sv ====
`timescale 1ns/1ps

module dcache_pipeline import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    dcache_array_if.pipe      arr,

    input  logic              req_valid_i,
    input  mem_op_e           req_op_i,
    input  mem_size_e         req_size_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [XLEN-1:0]   req_data_i,
    input  logic [ROB_W-1:0]  req_rob_i,
    output logic              req_ready_o,

    output logic              s2_resp_valid_o,
    output logic [XLEN-1:0]   s2_ld_data_o,
    output logic [ROB_W-1:0]  s2_rob_o,

    output logic              miss_valid_o,
    output miss_req_t         miss_req_o,
    input  logic              mshr_busy_i
);

    logic              req_hsk;

    logic              s1_valid;
    mem_op_e           s1_op;
    mem_size_e         s1_size;
    logic [ADDR_W-1:0] s1_addr;
    logic [XLEN-1:0]   s1_data;
    logic [ROB_W-1:0]  s1_rob;
    logic              s1_hit;
    logic              s1_miss;

    logic              s2_valid;
    mem_op_e           s2_op;
    mem_size_e         s2_size;
    logic [ADDR_W-1:0] s2_addr;
    logic [XLEN-1:0]   s2_data;
    logic [ROB_W-1:0]  s2_rob;
    logic [XLEN-1:0]   s2_line;

    //////////////////////////////////////////////////
    // s0 accept and array read
    assign req_ready_o = arr.init_done && !mshr_busy_i
                         && !(s1_valid && s1_op == OP_STORE)
                         && !(s2_valid && s2_op == OP_STORE)
                         && !s1_miss;
    assign req_hsk = req_valid_i && req_ready_o;

    assign arr.rd_en    = req_hsk;
    assign arr.rd_index = req_addr_i[OFFSET_W +: INDEX_W];

    //////////////////////////////////////////////////
    // s1 tag compare
    assign s1_hit  = s1_valid && arr.rd_tag.valid
                     && (arr.rd_tag.tag == s1_addr[ADDR_W-1:TAG_LSB]);
    assign s1_miss = s1_valid && !s1_hit;

    assign miss_valid_o = s1_miss;     // s1 empties next cycle

    always_comb begin
        miss_req_o.op          = s1_op;
        miss_req_o.size        = s1_size;
        miss_req_o.addr        = s1_addr;
        miss_req_o.st_data     = s1_data;
        miss_req_o.rob         = s1_rob;
        miss_req_o.victim      = arr.rd_tag;
        miss_req_o.victim_data = arr.rd_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req_hsk;
            s2_valid <= s1_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (req_hsk) begin
            s1_op   <= req_op_i;
            s1_size <= req_size_i;
            s1_addr <= req_addr_i;
            s1_data <= req_data_i;
            s1_rob  <= req_rob_i;
        end
        if (s1_hit) begin
            s2_op   <= s1_op;
            s2_size <= s1_size;
            s2_addr <= s1_addr;
            s2_data <= s1_data;
            s2_rob  <= s1_rob;
            s2_line <= arr.rd_data;
        end
    end

    //////////////////////////////////////////////////
    // s2 load response / store write
    assign s2_resp_valid_o = s2_valid && s2_op == OP_LOAD;
    assign s2_ld_data_o    = load_align(s2_line, s2_addr[OFFSET_W-1:0], s2_size);
    assign s2_rob_o        = s2_rob;

    assign arr.wr_en    = s2_valid && s2_op == OP_STORE;
    assign arr.wr_index = s2_addr[OFFSET_W +: INDEX_W];
    assign arr.wr_mask  = byte_mask(s2_size, s2_addr[OFFSET_W-1:0]);
    assign arr.wr_data  = store_merge(s2_line, s2_data, s2_size, s2_addr[OFFSET_W-1:0]);
    assign arr.wr_tag   = '{valid: 1'b1, dirty: 1'b1, tag: s2_addr[ADDR_W-1:TAG_LSB]};

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_dcache -o tb_dcache_sim

out=$(./obj_dir/tb_dcache_sim 2>&1 || true)
printf '%s\n' "$out"

# exit status of grep decides the result
printf '%s\n' "$out" | grep -q "^Simulation completed successfully$"

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;   // 8 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== testbench/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    // ~4000 cycles expected: clear sweep plus ~300 misses of about 12 cycles
    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    mem_op_e           req_op;
    mem_size_e         req_size;
    logic [ADDR_W-1:0] req_addr;
    logic [XLEN-1:0]   req_data;
    logic [ROB_W-1:0]  req_rob;
    logic              req_ready;
    logic              resp_valid;
    logic [XLEN-1:0]   ld_data;
    logic [ROB_W-1:0]  rob;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [XLEN-1:0]   wb_dat_w;
    logic [XLEN-1:0]   wb_dat_r;
    logic              wb_ack;
    int                wr_count;
    int                rd_count;
    logic [ADDR_W-1:0] last_wr_adr;
    logic [XLEN-1:0]   last_wr_dat;

    logic [XLEN-1:0]   model_mem [logic [ADDR_W-OFFSET_W-1:0]];
    logic [65:0]       exp_q [$];   // {rob, data} in issue order
    logic [65:0]       exp_entry;
    logic [31:0]       rng_state;
    string             cur_test;
    int                error_count;
    int                resp_count;
    int                cycle_cnt;

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    tb_wb_mem u_mem (
        .clk           (clk),
        .cyc_i         (wb_cyc),
        .stb_i         (wb_stb),
        .we_i          (wb_we),
        .adr_i         (wb_adr),
        .dat_i         (wb_dat_w),
        .ack_o         (wb_ack),
        .dat_o         (wb_dat_r),
        .wr_count_o    (wr_count),
        .rd_count_o    (rd_count),
        .last_wr_adr_o (last_wr_adr),
        .last_wr_dat_o (last_wr_dat)
    );

    dcache_top i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .req_valid_i  (req_valid),
        .req_op_i     (req_op),
        .req_size_i   (req_size),
        .req_addr_i   (req_addr),
        .req_data_i   (req_data),
        .req_rob_i    (req_rob),
        .req_ready_o  (req_ready),
        .resp_valid_o (resp_valid),
        .ld_data_o    (ld_data),
        .rob_o        (rob),
        .wb_cyc_o     (wb_cyc),
        .wb_stb_o     (wb_stb),
        .wb_we_o      (wb_we),
        .wb_adr_o     (wb_adr),
        .wb_dat_o     (wb_dat_w),
        .wb_ack_i     (wb_ack),
        .wb_dat_i     (wb_dat_r)
    );

    //////////////////////////////////////////////////
    // reference model
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [63:0] model_line(input logic [31:0] addr);
        if (model_mem.exists(addr[31:3])) begin
            return model_mem[addr[31:3]];
        end
        return 64'({addr[31:3], 3'b000}) * 64'h9E3779B97F4A7C15;
    endfunction

    function automatic logic [63:0] ref_load(input logic [63:0] line, input logic [2:0] off,
                                             input logic [2:0] size);
        int          nbytes;
        logic        sign;
        logic [63:0] val;
        nbytes = 1 << size[1:0];
        val = '0;
        for (int b = 0; b < nbytes; b++) begin
            val[8*b +: 8] = line[8*(off + b) +: 8];
        end
        sign = !size[2] && val[8*nbytes-1];   // size bit 2 means unsigned
        for (int b = nbytes; b < 8; b++) begin
            val[8*b +: 8] = {8{sign}};
        end
        return val;
    endfunction

    function automatic logic [63:0] ref_store(input logic [63:0] line, input logic [63:0] data,
                                              input logic [2:0] size, input logic [2:0] off);
        logic [63:0] res;
        res = line;
        for (int b = 0; b < (1 << size[1:0]); b++) begin
            res[8*(off + b) +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        error_count++;
        $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, expected, actual);
    endtask

    //////////////////////////////////////////////////
    // request driving, called right after a rising edge
    task automatic issue_req(input mem_op_e op, input logic [2:0] size, input logic [31:0] addr,
                             input logic [63:0] data, input logic [1:0] rob_tag);
        logic [63:0] line;
        req_valid <= 1'b1;
        req_op    <= op;
        req_size  <= mem_size_e'(size);
        req_addr  <= addr;
        req_data  <= data;
        req_rob   <= rob_tag;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);   // transfer edge
        line = model_line(addr);
        if (op == OP_STORE) begin
            model_mem[addr[31:3]] = ref_store(line, data, size, addr[2:0]);
        end else begin
            exp_q.push_back({rob_tag, ref_load(line, addr[2:0], size)});
        end
    endtask

    task automatic drain();
        req_valid <= 1'b0;
        @(negedge clk);
        while (exp_q.size() != 0 || !req_ready) @(negedge clk);
        @(posedge clk);
    endtask

    // response checker, outputs are settled at the falling edge
    always @(negedge clk) begin
        if (resp_valid) begin
            resp_count++;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("response arrived with no load outstanding in test %s", cur_test);
            end else begin
                exp_entry = exp_q.pop_front();
                if (ld_data !== exp_entry[63:0]) begin
                    report_mismatch("load data", exp_entry[63:0], ld_data);
                end
                if (rob !== exp_entry[65:64]) begin
                    report_mismatch("rob", 64'(exp_entry[65:64]), 64'(rob));
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // tests
    task automatic test_cold_miss();
        int          writes_before;
        logic [31:0] addr;
        cur_test = "cold_miss";
        writes_before = wr_count;
        for (int i = 0; i < 4; i++) begin
            addr = next_rand() & 32'hffff_fff8;
            issue_req(OP_LOAD, SIZE_D, addr, '0, 2'(i));
        end
        drain();
        if (wr_count != writes_before) begin
            report_mismatch("wb writes", 64'(writes_before), 64'(wr_count));
        end
    endtask

    task automatic test_load_ext();
        logic [31:0] base;
        cur_test = "load_ext";
        base = next_rand() & 32'hffff_fff8;
        // bytes and halves of both signs
        issue_req(OP_STORE, SIZE_D, base, 64'h7001_80fe_ff80_017f, 2'd0);
        for (int s = 0; s < 7; s++) begin
            for (int off = 0; off < 8; off += (1 << (s % 4))) begin
                issue_req(OP_LOAD, 3'(s), base + 32'(off), '0, 2'(off));
            end
        end
        drain();
    endtask

    task automatic test_store_hit();
        logic [31:0] base;
        logic [63:0] data;
        cur_test = "store_hit";
        base = next_rand() & 32'hffff_fff8;
        data = {next_rand(), next_rand()};
        issue_req(OP_LOAD, SIZE_D, base, '0, 2'd1);   // allocate
        issue_req(OP_STORE, SIZE_H, base + 2, data, 2'd0);
        issue_req(OP_LOAD, SIZE_D, base, '0, 2'd2);
        issue_req(OP_STORE, SIZE_B, base + 7, data, 2'd0);
        issue_req(OP_LOAD, SIZE_D, base, '0, 2'd3);
        issue_req(OP_LOAD, SIZE_HU, base + 2, '0, 2'd0);
        drain();
    endtask

    task automatic test_dirty_evict();
        int          writes_before;
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        cur_test = "dirty_evict";
        addr_a = next_rand() & 32'hffff_fff8;
        addr_b = addr_a ^ 32'h0000_0800;   // same index, other tag
        issue_req(OP_STORE, SIZE_W, addr_a + 4, {next_rand(), next_rand()}, 2'd0);
        drain();
        writes_before = wr_count;
        issue_req(OP_LOAD, SIZE_D, addr_b, '0, 2'd1);
        drain();
        if (wr_count != writes_before + 1) begin
            report_mismatch("wb writes", 64'(writes_before + 1), 64'(wr_count));
        end
        if (last_wr_adr !== addr_a) begin
            report_mismatch("writeback address", 64'(addr_a), 64'(last_wr_adr));
        end
        if (last_wr_dat !== model_line(addr_a)) begin
            report_mismatch("writeback data", model_line(addr_a), last_wr_dat);
        end
        issue_req(OP_LOAD, SIZE_W, addr_a + 4, '0, 2'd2);
        drain();
    endtask

    task automatic test_store_miss();
        int          reads_before;
        logic [31:0] addr;
        cur_test = "store_miss";
        addr = next_rand() & 32'hffff_fff8;
        issue_req(OP_STORE, SIZE_W, addr + 4, {next_rand(), next_rand()}, 2'd0);
        drain();
        reads_before = rd_count;
        issue_req(OP_LOAD, SIZE_D, addr, '0, 2'd1);
        issue_req(OP_LOAD, SIZE_WU, addr + 4, '0, 2'd2);
        drain();
        if (rd_count != reads_before) begin
            report_mismatch("wb reads on hit", 64'(reads_before), 64'(rd_count));
        end
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [2:0]  size;
        logic [2:0]  off;
        logic [20:0] tag;
        logic [7:0]  idx;
        cur_test = "random";
        for (int i = 0; i < 200; i++) begin
            r    = next_rand();
            size = 3'(r[6:4] % 7);
            off  = r[2:0] & ~(3'((1 << size[1:0]) - 1));   // naturally aligned
            tag  = 21'h0a5a5 + 21'(r[9:8] % 3);
            idx  = 8'h40 + 8'(r[11:10]);
            issue_req(r[12] ? OP_STORE : OP_LOAD, size, {tag, idx, off},
                      {next_rand(), next_rand()}, 2'(i));
        end
        drain();
    endtask

    //////////////////////////////////////////////////
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: DUT made no progress within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        req_valid   = 1'b0;
        req_op      = OP_LOAD;
        req_size    = SIZE_D;
        req_addr    = '0;
        req_data    = '0;
        req_rob     = '0;
        rng_state   = 32'h15c9;
        error_count = 0;
        resp_count  = 0;
        cycle_cnt   = 0;
        cur_test    = "reset";
        @(posedge rst_n);
        @(negedge clk);
        if (req_ready || resp_valid || wb_cyc || wb_stb) begin
            error_count++;
            $display("outputs not idle after reset");
        end
        @(posedge clk);
        test_cold_miss();
        test_load_ext();
        test_store_hit();
        test_dirty_evict();
        test_store_miss();
        test_random();
        $display("%0d responses checked, %0d errors", resp_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_dcache_properties.sv ====
`timescale 1ns/1ps

module tb_dcache_properties import dcache_pkg::*; (
    input logic              clk,
    input logic              rst_n_i,
    input logic              req_ready_i,
    input logic              cyc_i,
    input logic              stb_i,
    input logic              ack_i,
    input logic [ADDR_W-1:0] adr_i
);

    a_stb_follows_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
        stb_i == cyc_i)
        else $error("wb_stb_o differs from wb_cyc_o");

    // address held until the slave acks
    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        cyc_i && !ack_i |=> $stable(adr_i))
        else $error("wb_adr_o changed during a bus cycle");

    a_no_accept_on_bus: assert property (@(posedge clk) disable iff (!rst_n_i)
        cyc_i |-> !req_ready_i)
        else $error("req_ready_o high while the bus is busy");

endmodule

bind dcache_top tb_dcache_properties i_props (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_ready_i (req_ready_o),
    .cyc_i       (wb_cyc_o),
    .stb_i       (wb_stb_o),
    .ack_i       (wb_ack_i),
    .adr_i       (wb_adr_o)
);

// ==== testbench/tb_wb_mem.sv ====
`timescale 1ns/1ps

module tb_wb_mem import dcache_pkg::*; (
    input  logic              clk,
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] adr_i,
    input  logic [XLEN-1:0]   dat_i,
    output logic              ack_o,
    output logic [XLEN-1:0]   dat_o,
    output int                wr_count_o,
    output int                rd_count_o,
    output logic [ADDR_W-1:0] last_wr_adr_o,
    output logic [XLEN-1:0]   last_wr_dat_o
);

    logic [XLEN-1:0]            mem [logic [ADDR_W-OFFSET_W-1:0]];   // sparse, one entry per line
    logic                       wait_q;
    logic [ADDR_W-OFFSET_W-1:0] line;

    assign line = adr_i[ADDR_W-1:OFFSET_W];

    initial begin
        ack_o         = 1'b0;
        dat_o         = '0;
        wait_q        = 1'b0;
        wr_count_o    = 0;
        rd_count_o    = 0;
        last_wr_adr_o = '0;
        last_wr_dat_o = '0;
    end

    // ack comes two cycles after cyc/stb rise, one cycle wide
    always @(posedge clk) begin
        ack_o <= 1'b0;
        if (cyc_i && stb_i && !ack_o) begin
            wait_q <= !wait_q;
            if (wait_q) begin
                ack_o <= 1'b1;
                if (we_i) begin
                    mem[line] = dat_i;
                    wr_count_o    <= wr_count_o + 1;
                    last_wr_adr_o <= adr_i;
                    last_wr_dat_o <= dat_i;
                end else begin
                    rd_count_o <= rd_count_o + 1;
                    // untouched lines hold line byte address times an odd constant
                    dat_o <= mem.exists(line) ? mem[line] :
                             64'({line, 3'b000}) * 64'h9E3779B97F4A7C15;
                end
            end
        end
    end

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic              req_valid_i,
    input  mem_op_e           req_op_i,
    input  mem_size_e         req_size_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [XLEN-1:0]   req_data_i,
    input  logic [ROB_W-1:0]  req_rob_i,
    output logic              req_ready_o,

    output logic              resp_valid_o,
    output logic [XLEN-1:0]   ld_data_o,
    output logic [ROB_W-1:0]  rob_o,

    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output logic [XLEN-1:0]   wb_dat_o,
    input  logic              wb_ack_i,
    input  logic [XLEN-1:0]   wb_dat_i
);

    logic              s2_resp_valid;
    logic [XLEN-1:0]   s2_ld_data;
    logic [ROB_W-1:0]  s2_rob;
    logic              fill_resp_valid;
    logic [XLEN-1:0]   fill_ld_data;
    logic [ROB_W-1:0]  fill_rob;
    logic              miss_valid;
    miss_req_t         miss_req;
    logic              mshr_busy;

    dcache_array_if arr_if ();

    dcache_arrays u_arrays (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .arr     (arr_if.array)
    );

    dcache_pipeline u_pipeline (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .arr             (arr_if.pipe),
        .req_valid_i     (req_valid_i),
        .req_op_i        (req_op_i),
        .req_size_i      (req_size_i),
        .req_addr_i      (req_addr_i),
        .req_data_i      (req_data_i),
        .req_rob_i       (req_rob_i),
        .req_ready_o     (req_ready_o),
        .s2_resp_valid_o (s2_resp_valid),
        .s2_ld_data_o    (s2_ld_data),
        .s2_rob_o        (s2_rob),
        .miss_valid_o    (miss_valid),
        .miss_req_o      (miss_req),
        .mshr_busy_i     (mshr_busy)
    );

    dcache_miss_unit u_miss_unit (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .arr               (arr_if.refill),
        .miss_valid_i      (miss_valid),
        .miss_req_i        (miss_req),
        .mshr_busy_o       (mshr_busy),
        .fill_resp_valid_o (fill_resp_valid),
        .fill_ld_data_o    (fill_ld_data),
        .fill_rob_o        (fill_rob),
        .wb_cyc_o          (wb_cyc_o),
        .wb_stb_o          (wb_stb_o),
        .wb_we_o           (wb_we_o),
        .wb_adr_o          (wb_adr_o),
        .wb_dat_o          (wb_dat_o),
        .wb_ack_i          (wb_ack_i),
        .wb_dat_i          (wb_dat_i)
    );

    // hit and refill responses never overlap
    assign resp_valid_o = s2_resp_valid || fill_resp_valid;
    assign ld_data_o    = fill_resp_valid ? fill_ld_data : s2_ld_data;
    assign rob_o        = fill_resp_valid ? fill_rob : s2_rob;

endmodule
